// File: lcd_pattern_pkg.sv
package lcd_pattern_pkg;

	// ------------------------------------------------------------------------
	// bar palette, 24-bit rgb888
	// ------------------------------------------------------------------------
	localparam logic [23:0] COLOR_RED    = 24'hff0000;
	localparam logic [23:0] COLOR_GREEN  = 24'h00ff00;
	localparam logic [23:0] COLOR_BLUE   = 24'h0000ff;
	localparam logic [23:0] COLOR_WHITE  = 24'hffffff;
	localparam logic [23:0] COLOR_BLACK  = 24'h000000;
	localparam logic [23:0] COLOR_YELLOW = 24'hffff00;
	localparam logic [23:0] COLOR_CYAN   = 24'h00ffff;
	localparam logic [23:0] COLOR_ROYAL  = 24'h4169e1;

	// top-to-bottom / left-to-right bar order
	localparam logic [23:0] BAR_PALETTE [0:7] = '{
		COLOR_RED, COLOR_GREEN, COLOR_BLUE, COLOR_WHITE,
		COLOR_BLACK, COLOR_YELLOW, COLOR_CYAN, COLOR_ROYAL
	};

	typedef enum logic [2:0] {
		MODE_HBAR    = 3'd0,
		MODE_VBAR    = 3'd1,
		MODE_GRAY    = 3'd2,
		MODE_PRODUCT = 3'd3,
		MODE_FRAME   = 3'd4
	} pixel_mode_t;

	// ------------------------------------------------------------------------
	// frame memory word, rgb565 or two gray pixels
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	typedef struct packed {
		logic [7:0] gray_hi;	// odd pixel
		logic [7:0] gray_lo;	// even pixel
	} gray_pair_t;

	typedef union packed {
		rgb565_t    rgb;
		gray_pair_t gray;
	} frame_word_u;

	// apb register map
	localparam logic [11:0] REG_CTRL   = 12'h000;
	localparam logic [11:0] REG_PERIOD = 12'h004;
	localparam logic [11:0] REG_STATUS = 12'h008;	// read only
	localparam logic [11:0] FRAME_BASE = 12'h400;

endpackage

// File: lcd_timing.sv
`timescale 1ns/1ps

module lcd_timing #(
	parameter int H_DISP  = 16,
	parameter int V_DISP  = 8,
	parameter int H_TOTAL = 24,
	parameter int V_TOTAL = 12,
	parameter int H_SYNC  = 2,
	parameter int V_SYNC  = 1,
	parameter int POS_W   = 12
) (
	input  logic             clk,
	input  logic             rst_n,
	output logic [POS_W-1:0] xpos,
	output logic [POS_W-1:0] ypos,
	output logic             de_raw,
	output logic             hsync_raw,
	output logic             vsync_raw,
	output logic             frame_start
);

	logic [POS_W-1:0] h_cnt;
	logic [POS_W-1:0] v_cnt;
	logic             line_end;
	logic             frame_end;
	logic             h_active;
	logic             v_active;

	assign line_end  = (h_cnt == POS_W'(H_TOTAL - 1));
	assign frame_end = (v_cnt == POS_W'(V_TOTAL - 1));

	// ------------------------------------------------------------------------
	// free-running line and frame counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else
		begin
			if (line_end)
			begin
				h_cnt <= '0;
				if (frame_end)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end
			else
			begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign h_active = (h_cnt < POS_W'(H_DISP));
	assign v_active = (v_cnt < POS_W'(V_DISP));
	assign de_raw   = h_active && v_active;

	// sync sits in the last counts of line / frame, active low
	assign hsync_raw = !(h_cnt >= POS_W'(H_TOTAL - H_SYNC));
	assign vsync_raw = !(v_cnt >= POS_W'(V_TOTAL - V_SYNC));

	assign frame_start = (h_cnt == '0) && (v_cnt == '0);

	// coordinates parked at zero in blanking
	assign xpos = de_raw ? h_cnt : '0;
	assign ypos = de_raw ? v_cnt : '0;

endmodule

// File: lcd_frame_ram.sv
`timescale 1ns/1ps

module lcd_frame_ram
	import lcd_pattern_pkg::*;
#(
	parameter int ADDR_W = 7
) (
	input  logic              clk,
	input  logic              we,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [ADDR_W-1:0] raddr,
	input  frame_word_u       wdata,
	output frame_word_u       rdata
);

	localparam int DEPTH = 1 << ADDR_W;

	frame_word_u mem [0:DEPTH-1];

	// ------------------------------------------------------------------------
	// write port, apb side
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// ------------------------------------------------------------------------
	// read port, display side
	// one cycle latency, old data on a same-address write
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

// File: lcd_frame_fetch.sv
`timescale 1ns/1ps

module lcd_frame_fetch
	import lcd_pattern_pkg::*;
#(
	parameter int H_DISP = 16,
	parameter int ADDR_W = 7,
	parameter int POS_W  = 12
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [POS_W-1:0]  xpos,
	input  logic [POS_W-1:0]  ypos,
	input  logic              format,
	output logic [ADDR_W-1:0] rd_addr,
	input  frame_word_u       rd_data,
	output logic [23:0]       fetch_pixel
);

	localparam int IDX_W = 2 * POS_W;

	logic [IDX_W-1:0] lin_idx;
	logic             odd_d;	// pixel parity, ram aligned
	logic             fmt_d;	// format, ram aligned
	logic [7:0]       red8;
	logic [7:0]       green8;
	logic [7:0]       blue8;
	logic [7:0]       gray8;

	// ------------------------------------------------------------------------
	// address stage
	// ------------------------------------------------------------------------
	assign lin_idx = ypos * IDX_W'(H_DISP) + IDX_W'(xpos);

	// gray words hold two pixels
	assign rd_addr = format ? lin_idx[ADDR_W:1] : lin_idx[ADDR_W-1:0];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			odd_d <= 1'b0;
			fmt_d <= 1'b0;
		end
		else
		begin
			odd_d <= lin_idx[0];
			fmt_d <= format;
		end
	end

	// ------------------------------------------------------------------------
	// decode stage
	// ------------------------------------------------------------------------
	always_comb
	begin
		// msb replication for 565 -> 888
		red8   = {rd_data.rgb.red, rd_data.rgb.red[4:2]};
		green8 = {rd_data.rgb.green, rd_data.rgb.green[5:4]};
		blue8  = {rd_data.rgb.blue, rd_data.rgb.blue[4:2]};
		gray8  = odd_d ? rd_data.gray.gray_hi : rd_data.gray.gray_lo;
	end

	always_ff @(posedge clk)
	begin
		if (fmt_d)
			fetch_pixel <= {3{gray8}};
		else
			fetch_pixel <= {red8, green8, blue8};
	end

endmodule

// File: lcd_pattern_gen.sv
`timescale 1ns/1ps

module lcd_pattern_gen
	import lcd_pattern_pkg::*;
#(
	parameter int H_DISP = 16,
	parameter int V_DISP = 8,
	parameter int POS_W  = 12
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [POS_W-1:0] xpos,
	input  logic [POS_W-1:0] ypos,
	input  logic             frame_start,
	input  pixel_mode_t      ctrl_mode,
	input  logic             ctrl_auto,
	input  logic [7:0]       period,
	input  logic [23:0]      fetch_pixel,
	output logic [23:0]      pixel,
	output pixel_mode_t      active_mode,
	output logic [7:0]       frame_cnt
);

	localparam int H_STEP = (H_DISP >= 8) ? H_DISP / 8 : 1;
	localparam int V_STEP = (V_DISP >= 8) ? V_DISP / 8 : 1;

	logic [23:0]        hbar_q;
	logic [23:0]        vbar_q;
	logic [23:0]        gray_q;
	logic [23:0]        prod_q;
	logic [23:0]        pat_q;
	logic [2*POS_W-1:0] prod_full;
	logic [7:0]         eff_period;
	logic [7:0]         cnt_next;
	pixel_mode_t        next_step;

	// which eighth of the span, then palette lookup
	function automatic logic [23:0] bar_color(input logic [POS_W-1:0] pos,
		input int unsigned step);
		int unsigned band;
		band = 0;
		for (int k = 1; k < 8; k++)
		begin
			if (pos >= step * k)
				band = k;
		end
		return BAR_PALETTE[band];
	endfunction

	// ------------------------------------------------------------------------
	// stage one, one register per source
	// ------------------------------------------------------------------------
	assign prod_full = xpos * ypos;

	always_ff @(posedge clk)
	begin
		hbar_q <= bar_color(ypos, V_STEP);
		vbar_q <= bar_color(xpos, H_STEP);
		if (ypos < POS_W'(V_DISP / 2))
			gray_q <= {3{ypos[7:0]}};	// upper half
		else
			gray_q <= {3{xpos[7:0]}};
		prod_q <= prod_full[23:0];
	end

	// stage two, registered mux; frame path is already two deep
	always_ff @(posedge clk)
	begin
		case (active_mode)
			MODE_HBAR: pat_q <= hbar_q;
			MODE_VBAR: pat_q <= vbar_q;
			MODE_GRAY: pat_q <= gray_q;
			default:   pat_q <= prod_q;
		endcase
	end

	assign pixel = (active_mode == MODE_FRAME) ? fetch_pixel : pat_q;

	// ------------------------------------------------------------------------
	// active mode, only ever changes at frame_start
	// ------------------------------------------------------------------------
	assign eff_period = (period == 8'd0) ? 8'd1 : period;
	assign cnt_next   = frame_cnt + 8'd1;
	assign next_step  = (active_mode >= MODE_FRAME) ? MODE_HBAR :
		pixel_mode_t'(active_mode + 3'd1);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active_mode <= MODE_HBAR;
			frame_cnt   <= '0;
		end
		else if (frame_start)
		begin
			if (ctrl_auto)
			begin
				if (cnt_next >= eff_period)
				begin
					active_mode <= next_step;	// slideshow step
					frame_cnt   <= '0;
				end
				else
				begin
					frame_cnt <= cnt_next;
				end
			end
			else
			begin
				// codes 5..7 fall back to bars
				active_mode <= (ctrl_mode > MODE_FRAME) ? MODE_HBAR : ctrl_mode;
				frame_cnt   <= '0;
			end
		end
	end

endmodule

// File: lcd_apb_regs.sv
`timescale 1ns/1ps

module lcd_apb_regs
	import lcd_pattern_pkg::*;
#(
	parameter int ADDR_W = 7
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [11:0]       paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              ram_we,
	output logic [ADDR_W-1:0] ram_waddr,
	output frame_word_u       ram_wdata,
	output pixel_mode_t       ctrl_mode,
	output logic              ctrl_auto,
	output logic              ctrl_format,
	output logic [7:0]        period,
	input  pixel_mode_t       active_mode,
	input  logic [7:0]        frame_cnt
);

	localparam int WIN_BYTES = 4 << ADDR_W;	// one 32-bit slot per word

	logic access;
	logic sel_ctrl;
	logic sel_period;
	logic sel_status;
	logic sel_ram;
	logic mapped;
	logic reg_wr;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------
	assign sel_ctrl   = (paddr == REG_CTRL);
	assign sel_period = (paddr == REG_PERIOD);
	assign sel_status = (paddr == REG_STATUS);
	assign sel_ram    = (paddr >= FRAME_BASE) &&
		(int'(paddr) < int'(FRAME_BASE) + WIN_BYTES);
	assign mapped     = sel_ctrl || sel_period || sel_status || sel_ram;

	assign access = psel && penable;
	assign reg_wr = access && pwrite;

	assign pready  = 1'b1;	// no wait states
	assign pslverr = access && !mapped;

	// frame window straight through to the ram
	assign ram_we    = reg_wr && sel_ram;
	assign ram_waddr = paddr[ADDR_W+1:2];
	assign ram_wdata = frame_word_u'(pwdata[15:0]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ctrl_mode   <= MODE_HBAR;
			ctrl_auto   <= 1'b0;
			ctrl_format <= 1'b0;
			period      <= '0;
		end
		else if (reg_wr)
		begin
			if (sel_ctrl)
			begin
				ctrl_mode   <= pixel_mode_t'(pwdata[2:0]);
				ctrl_auto   <= pwdata[3];
				ctrl_format <= pwdata[4];
			end
			if (sel_period)
				period <= pwdata[7:0];
		end
	end

	// read mux, window reads give zero
	always_comb
	begin
		prdata = '0;
		if (psel && !pwrite)
		begin
			if (sel_ctrl)
				prdata = {27'd0, ctrl_format, ctrl_auto, ctrl_mode};
			else if (sel_period)
				prdata = {24'd0, period};
			else if (sel_status)
				prdata = {16'd0, frame_cnt, 5'd0, active_mode};
		end
	end

endmodule

// File: lcd_pattern_top.sv
`timescale 1ns/1ps

module lcd_pattern_top
	import lcd_pattern_pkg::*;
#(
	parameter int H_DISP  = 16,
	parameter int V_DISP  = 8,
	parameter int H_TOTAL = 24,
	parameter int V_TOTAL = 12,
	parameter int H_SYNC  = 2,
	parameter int V_SYNC  = 1,
	parameter int ADDR_W  = 7,
	parameter int POS_W   = 12
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic [23:0] rgb,
	output logic        de,
	output logic        hsync,
	output logic        vsync
);

	logic [POS_W-1:0]  xpos;
	logic [POS_W-1:0]  ypos;
	logic              de_raw;
	logic              hsync_raw;
	logic              vsync_raw;
	logic              frame_start;
	logic              ram_we;
	logic [ADDR_W-1:0] ram_waddr;
	frame_word_u       ram_wdata;
	logic [ADDR_W-1:0] rd_addr;
	frame_word_u       rd_data;
	logic [23:0]       fetch_pixel;
	logic [23:0]       pixel;
	pixel_mode_t       ctrl_mode;
	logic              ctrl_auto;
	logic              ctrl_format;
	logic [7:0]        period;
	pixel_mode_t       active_mode;
	logic [7:0]        frame_cnt;
	logic [1:0]        de_dly;	// matches two-cycle pixel latency
	logic [1:0]        hs_dly;
	logic [1:0]        vs_dly;

	lcd_timing #(
		.H_DISP(H_DISP), .V_DISP(V_DISP), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
		.H_SYNC(H_SYNC), .V_SYNC(V_SYNC), .POS_W(POS_W)
	) u_timing (
		.clk(clk), .rst_n(rst_n), .xpos(xpos), .ypos(ypos), .de_raw(de_raw),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .frame_start(frame_start)
	);

	lcd_apb_regs #(.ADDR_W(ADDR_W)) u_regs (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .ram_we(ram_we), .ram_waddr(ram_waddr),
		.ram_wdata(ram_wdata), .ctrl_mode(ctrl_mode), .ctrl_auto(ctrl_auto),
		.ctrl_format(ctrl_format), .period(period), .active_mode(active_mode),
		.frame_cnt(frame_cnt)
	);

	lcd_frame_ram #(.ADDR_W(ADDR_W)) u_ram (
		.clk(clk), .we(ram_we), .waddr(ram_waddr), .raddr(rd_addr),
		.wdata(ram_wdata), .rdata(rd_data)
	);

	lcd_frame_fetch #(.H_DISP(H_DISP), .ADDR_W(ADDR_W), .POS_W(POS_W)) u_fetch (
		.clk(clk), .rst_n(rst_n), .xpos(xpos), .ypos(ypos), .format(ctrl_format),
		.rd_addr(rd_addr), .rd_data(rd_data), .fetch_pixel(fetch_pixel)
	);

	lcd_pattern_gen #(.H_DISP(H_DISP), .V_DISP(V_DISP), .POS_W(POS_W)) u_gen (
		.clk(clk), .rst_n(rst_n), .xpos(xpos), .ypos(ypos),
		.frame_start(frame_start), .ctrl_mode(ctrl_mode), .ctrl_auto(ctrl_auto),
		.period(period), .fetch_pixel(fetch_pixel), .pixel(pixel),
		.active_mode(active_mode), .frame_cnt(frame_cnt)
	);

	// ------------------------------------------------------------------------
	// sync delay and output register with blanking
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			de_dly <= '0;
			hs_dly <= '1;	// idle high
			vs_dly <= '1;
			rgb    <= '0;
			de     <= 1'b0;
			hsync  <= 1'b1;
			vsync  <= 1'b1;
		end
		else
		begin
			de_dly <= {de_dly[0], de_raw};
			hs_dly <= {hs_dly[0], hsync_raw};
			vs_dly <= {vs_dly[0], vsync_raw};
			rgb    <= de_dly[1] ? pixel : 24'd0;
			de     <= de_dly[1];
			hsync  <= hs_dly[1];
			vsync  <= vs_dly[1];
		end
	end

endmodule

// File: lcd_pattern_chk.sv
`timescale 1ns/1ps

module lcd_pattern_chk (
	input logic        clk,
	input logic        rst_n,
	input logic [23:0] rgb,
	input logic        de,
	input logic        hsync,
	input logic        psel,
	input logic        penable,
	input logic        pslverr,
	input logic [2:0]  active_mode
);

	int assert_fails = 0;	// failed assertion count

	// ------------------------------------------------------------------------
	// display side
	// ------------------------------------------------------------------------
	a_blank_rgb: assert property (@(posedge clk) disable iff (!rst_n) !de |-> rgb == 24'd0)
		else begin assert_fails++; $error("rgb not zero outside de"); end

	a_hsync_de: assert property (@(posedge clk) disable iff (!rst_n) de |-> hsync)
		else begin assert_fails++; $error("hsync low inside de"); end

	a_mode_range: assert property (@(posedge clk) disable iff (!rst_n) active_mode <= 3'd4)
		else begin assert_fails++; $error("active mode out of range"); end

	// apb error only in an access cycle
	a_err_access: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> psel && penable)
		else begin assert_fails++; $error("pslverr outside access cycle"); end

endmodule

bind lcd_pattern_top lcd_pattern_chk u_chk (
	.clk(clk), .rst_n(rst_n), .rgb(rgb), .de(de), .hsync(hsync), .psel(psel),
	.penable(penable), .pslverr(pslverr), .active_mode(active_mode)
);

// File: lcd_pattern_tb.sv
`timescale 1ns/1ps

module lcd_pattern_tb
	import lcd_pattern_pkg::*;
();

	localparam int H_DISP       = 16;
	localparam int V_DISP       = 8;
	localparam int H_TOTAL      = 24;
	localparam int V_TOTAL      = 12;
	localparam int H_SYNC       = 2;
	localparam int V_SYNC       = 1;
	localparam int ADDR_W       = 7;
	localparam int POS_W        = 12;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int RAM_WORDS    = 1 << ADDR_W;
	localparam string TRACE_FILE = "lcd_pattern_trace.txt";

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [23:0] rgb;
	logic        de;
	logic        hsync;
	logic        vsync;

	// reference model state
	logic [15:0] shadow_ram [0:RAM_WORDS-1];
	logic [2:0]  shadow_mode;
	logic        shadow_auto;
	logic        shadow_format;
	logic [7:0]  shadow_period;
	logic [2:0]  model_mode;
	logic [7:0]  model_cnt;
	int          frame_phase;
	logic [23:0] bar_colors [0:7];
	longint      cycles;
	longint      cycle_limit;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	lcd_pattern_top #(
		.H_DISP(H_DISP), .V_DISP(V_DISP), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL),
		.H_SYNC(H_SYNC), .V_SYNC(V_SYNC), .ADDR_W(ADDR_W), .POS_W(POS_W)
	) UUT (
		.clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .rgb(rgb), .de(de), .hsync(hsync), .vsync(vsync)
	);

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// stop at the first failed bound assertion
	always @(posedge clk)
	begin
		if (UUT.u_chk.assert_fails != 0)
		begin
			$display("a bound assertion failed, see the error above");
			$display("Simulation failed");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch at %0d ns: %s expected %h actual %h", $time, name,
				expected, actual);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	// counters run from reset, so frame_start lands every FRAME_CYCLES edges
	task automatic step_frame();
		logic [7:0] limit;
		limit = (shadow_period == 8'd0) ? 8'd1 : shadow_period;
		if (shadow_auto)
		begin
			if (model_cnt + 8'd1 == limit)
			begin
				model_mode = (model_mode == 3'd4) ? 3'd0 : model_mode + 3'd1;
				model_cnt  = 8'd0;
			end
			else
				model_cnt = model_cnt + 8'd1;
		end
		else
		begin
			model_mode = (shadow_mode > 3'd4) ? 3'd0 : shadow_mode;
			model_cnt  = 8'd0;
		end
	endtask

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			model_mode  = 3'd0;
			model_cnt   = 8'd0;
			frame_phase = 0;
		end
		else
		begin
			if (frame_phase == 0)
				step_frame();
			frame_phase = (frame_phase == FRAME_CYCLES - 1) ? 0 : frame_phase + 1;
		end
	end

	function automatic logic [31:0] model_status();
		return {16'd0, model_cnt, 5'd0, model_mode};
	endfunction

	function automatic logic [23:0] expected_pixel(input int x, input int y);
		int          h_step;
		int          v_step;
		int          idx;
		logic [15:0] word;
		logic [7:0]  gray;
		h_step = (H_DISP >= 8) ? H_DISP / 8 : 1;
		v_step = (V_DISP >= 8) ? V_DISP / 8 : 1;
		idx    = y * H_DISP + x;
		case (model_mode)
			MODE_HBAR: return bar_colors[(y / v_step > 7) ? 7 : y / v_step];
			MODE_VBAR: return bar_colors[(x / h_step > 7) ? 7 : x / h_step];
			MODE_GRAY:
			begin
				gray = (y < V_DISP / 2) ? 8'(y) : 8'(x);
				return {3{gray}};
			end
			MODE_PRODUCT: return 24'(x * y);
			default:
			begin
				if (!shadow_format)
				begin
					word = shadow_ram[idx % RAM_WORDS];	// rgb565, top bits repeated
					return {word[15:11], word[15:13], word[10:5], word[10:9],
						word[4:0], word[4:2]};
				end
				word = shadow_ram[(idx / 2) % RAM_WORDS];
				gray = (idx % 2 == 1) ? word[15:8] : word[7:0];
				return {3{gray}};
			end
		endcase
	endfunction

	function automatic logic in_window(input logic [11:0] addr);
		return (addr >= FRAME_BASE) && (int'(addr) < int'(FRAME_BASE) + 4 * RAM_WORDS);
	endfunction

	function automatic logic is_unmapped(input logic [11:0] addr);
		return !(addr == REG_CTRL || addr == REG_PERIOD || addr == REG_STATUS ||
			in_window(addr));
	endfunction

	function automatic logic [15:0] fill_word(input int i);
		logic [6:0] a;
		a = 7'(i);
		return {a ^ 7'h2b, 2'b10, ~a};
	endfunction

	task automatic commit_write(input logic [11:0] addr, input logic [31:0] data);
		if (addr == REG_CTRL)
		begin
			shadow_mode   = data[2:0];
			shadow_auto   = data[3];
			shadow_format = data[4];
		end
		else if (addr == REG_PERIOD)
			shadow_period = data[7:0];
		else if (in_window(addr))
			shadow_ram[(int'(addr) - int'(FRAME_BASE)) / 4] = data[15:0];
	endtask

	// ------------------------------------------------------------------------
	// apb master
	// ------------------------------------------------------------------------
	task automatic apb_xfer(input logic wr, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output logic [31:0] snap);
		repeat ($urandom % 4) @(posedge clk);	// idle gap
		@(posedge clk);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err   = pslverr;
		snap  = model_status();
		check_value("pready", 32'd1, 32'(pready));
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		if (wr && !is_unmapped(addr))
			commit_write(addr, wdata);
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		logic [31:0] snap;
		apb_xfer(1'b1, addr, data, rdata, err, snap);
		check_value("pslverr", 32'(is_unmapped(addr)), 32'(err));
	endtask

	task automatic apb_read(input logic [11:0] addr, input logic [31:0] expected,
		input logic use_model, input logic exp_err);
		logic [31:0] rdata;
		logic        err;
		logic [31:0] snap;
		apb_xfer(1'b0, addr, 32'd0, rdata, err, snap);
		check_value("prdata", use_model ? snap : expected, rdata);
		check_value("pslverr", 32'(exp_err), 32'(err));
	endtask

	task automatic preload_ram();
		for (int i = 0; i < RAM_WORDS; i++)
			apb_write(12'(int'(FRAME_BASE) + 4 * i), {16'd0, fill_word(i)});
	endtask

	// ------------------------------------------------------------------------
	// frame capture, pixels counted from the first de after a vsync fall
	// ------------------------------------------------------------------------
	task automatic capture_frames(input int count);
		int   pix;
		int   run;
		int   lines;
		int   hs_low;
		logic vs_prev;
		for (int f = 0; f < count; f++)
		begin
			vs_prev = vsync;
			@(negedge clk);
			while (!(vs_prev && !vsync))
			begin
				if (f != 0)
					check_value("de", 32'd0, 32'(de));	// no extra lines
				vs_prev = vsync;
				@(negedge clk);
			end
			pix    = 0;
			run    = 0;
			lines  = 0;
			hs_low = 0;
			while (lines < V_DISP)
			begin
				@(negedge clk);
				if (!hsync)
					hs_low++;
				if (de)
				begin
					if (run == 0)
					begin
						// one hsync pulse ahead of every line
						check_value("hsync low cycles", H_SYNC, hs_low);
						hs_low = 0;
					end
					check_value("rgb", expected_pixel(pix % H_DISP, pix / H_DISP),
						32'(rgb));
					pix++;
					run++;
				end
				else if (run != 0)
				begin
					check_value("de cycles per line", H_DISP, run);
					run = 0;
					lines++;
				end
			end
		end
	endtask

	// dry pass only counts, for the cycle limit
	task automatic run_trace(input logic dry, output int n_apb, output int n_frames);
		int          fd;
		int          code;
		int          err;
		int          count;
		string       op;
		string       line;
		string       tok;
		logic [31:0] addr;
		logic [31:0] data;
		n_apb    = 0;
		n_frames = 0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file %s", TRACE_FILE);
			$display("Simulation failed");
			$fatal(1, "no stimulus");
		end
		while ($fscanf(fd, "%s", op) == 1)
		begin
			if (op.substr(0, 0) == "#")
				code = $fgets(line, fd);
			else if (op == "W")
			begin
				code = $fscanf(fd, "%h %h", addr, data);
				n_apb++;
				if (!dry)
					apb_write(addr[11:0], data);
			end
			else if (op == "R")
			begin
				code = $fscanf(fd, "%h %s %d", addr, tok, err);
				n_apb++;
				data = 32'd0;
				if (tok != "s")
					code = $sscanf(tok, "%h", data);
				if (!dry)
					apb_read(addr[11:0], data, tok == "s", err != 0);
			end
			else if (op == "F")
			begin
				code = $fscanf(fd, "%d", count);
				n_frames += count;
				if (!dry)
					capture_frames(count);
			end
			else
			begin
				$display("unknown operation %s in the trace file", op);
				$display("Simulation failed");
				$fatal(1, "bad trace");
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		int          n_apb;
		int          n_frames;
		int unsigned seed;
		rst_n         = 1'b0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		cycles        = 0;
		cycle_limit   = 0;
		shadow_mode   = 3'd0;
		shadow_auto   = 1'b0;
		shadow_format = 1'b0;
		shadow_period = 8'd0;
		seed          = $urandom(32'h4558_e6a4);
		bar_colors    = '{COLOR_RED, COLOR_GREEN, COLOR_BLUE, COLOR_WHITE,
			COLOR_BLACK, COLOR_YELLOW, COLOR_CYAN, COLOR_ROYAL};

		run_trace(1'b1, n_apb, n_frames);
		cycle_limit = 2 * (longint'(n_frames) * FRAME_CYCLES + 50 * (n_apb + RAM_WORDS + 1));

		// reset values while still in reset
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_value("de", 32'd0, 32'(de));
		check_value("hsync", 32'd1, 32'(hsync));
		check_value("vsync", 32'd1, 32'(vsync));
		check_value("rgb", 32'd0, 32'(rgb));
		check_value("pslverr", 32'd0, 32'(pslverr));
		@(posedge clk);
		#2;
		rst_n = 1'b1;

		preload_ram();
		run_trace(1'b0, n_apb, n_frames);
		repeat (4) @(posedge clk);

		if (UUT.u_chk.assert_fails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: lcd_pattern_trace.txt
# W addr data | R addr expected_data expected_pslverr, s takes STATUS from the model
# F frames, capture that many whole frames and compare every de pixel
R 000 00000000 0
R 008 00000000 0
R 004 00000000 0
F 1
W 000 00000001
R 000 00000001 0
F 1
W 000 00000002
F 1
W 000 00000003
F 1
W 400 0000f800
W 404 000007e0
W 408 0000001f
W 5fc 0000a5c3
W 000 00000004
F 1
W 000 00000014
R 000 00000014 0
F 1
W 004 00000002
W 000 00000008
R 004 00000002 0
R 008 s 0
F 12
R 008 s 0
W 600 000000ff
R 600 00000000 1
W 00c 00000007
W 008 00000003
R 008 s 0
R 000 00000008 0
R 004 00000002 0
R 404 00000000 0

// File: lcd_pattern.f
lcd_pattern_pkg.sv
lcd_timing.sv
lcd_frame_ram.sv
lcd_frame_fetch.sv
lcd_pattern_gen.sv
lcd_apb_regs.sv
lcd_pattern_top.sv
lcd_pattern_chk.sv
lcd_pattern_tb.sv
